/* cpuTestdata.txt */
// Word image for $readmemh. @000 program words, @080 data words preset at byte 0x40,
// @090 store count, @091 expected stores as: address data group (1 arith 2 shift 3 mem 4 branch).
@000
00700093 FFD00113 002081B3 00302023 // x1 = 7, x2 = -3, add, sw 0x00
40208233 00402223                   // sub, sw 0x04
0020F2B3 0020E333 00502423 00602623 // and, or, sw 0x08, sw 0x0C
00100393 01F00413                   // x7 = 1, x8 = 31
000114B3 00902823 00711533 00A02A23 // sll by 0, sll by 1
008096B3 00D02C23                   // sll by 31
00015733 00E02E23 00715633 02C02023 // srl by 0, srl by 1
008155B3 02B02223                   // srl by 31
04000893 0008A783 02F02423          // x17 = 0x40, lw preset word, sw 0x28
00D8A223 0048A803 03002623          // sw 0x44, lw it back, sw 0x2C
00708463 02102823                   // beq not taken, sw 0x30
00108463 02202A23                   // beq taken, skipped sw
00109463 02702A23                   // bne not taken, sw 0x34
00209463 02202C23                   // bne taken, skipped sw
0080096F 02202C23 03202C23          // jal x18, skipped sw, link to 0x38
0000006F                            // Spin.
@080
0BADF00D 5EED1234 0000C0DE 00FACADE
@090
00000010
00000000 00000004 00000001
00000004 0000000A 00000001
00000008 00000005 00000001
0000000C FFFFFFFF 00000001
00000010 FFFFFFFD 00000002
00000014 FFFFFFFA 00000002
00000018 80000000 00000002
0000001C FFFFFFFD 00000002
00000020 7FFFFFFE 00000002
00000024 00000001 00000002
00000028 0BADF00D 00000003
00000044 80000000 00000003
0000002C 80000000 00000003
00000030 00000007 00000004
00000034 00000001 00000004
00000038 0000009C 00000004

/* compile.f */
cpuPkg.sv
controlFsm.sv
fetchUnit.sv
instrDecoder.sv
regFile.sv
serialAlu.sv
cpuCore.sv
tbCpuCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpuCore
RTL_TOP   ?= cpuCore
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
RTL_SRCS  ?= cpuPkg.sv controlFsm.sv fetchUnit.sv instrDecoder.sv regFile.sv \
             serialAlu.sv cpuCore.sv
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* tbCpuCore.sv */
`default_nettype none
`timescale 1ns/1ps

module tbCpuCore import cpuPkg::*; ();

    localparam int          clockHalf     = 20;
    localparam int          resetCycles   = 5;
    localparam int          reqTimeout    = 600;
    localparam int          ackTimeout    = 20;
    localparam int          runLimit      = 5000;
    localparam int          dataInitBase  = 'h80;
    localparam int          storeCountPos = 'h90;
    localparam int          storeBase     = 'h91;
    localparam logic [31:0] seed          = 32'he89777fb;

    logic            Clock;
    logic            rstN;
    logic            instrReq;
    logic [xlen-1:0] instrAddr;
    logic            instrAck;
    logic [xlen-1:0] instrData;
    logic            dataReq;
    logic            dataWe;
    logic [xlen-1:0] dataAddr;
    logic [xlen-1:0] dataWdata;
    logic            dataAck;
    logic [xlen-1:0] dataRdata;

    logic [31:0] testData [256];
    logic [31:0] dmem [64];
    int          storeCount;
    int          storeIndex;
    int          errorCount;
    int          passCount;
    int          handshakeErrors;
    int          instrRequests;
    int          dataRequests;
    logic        hung = 1'b0;

    cpuCore u_dut (
        .Clock     (Clock),
        .rstN      (rstN),
        .instrReq  (instrReq),
        .instrAddr (instrAddr),
        .instrAck  (instrAck),
        .instrData (instrData),
        .dataReq   (dataReq),
        .dataWe    (dataWe),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataAck   (dataAck),
        .dataRdata (dataRdata)
    );

    initial Clock = 1'b0;
    always #clockHalf Clock = ~Clock;

    // ##################################################
    // Helpers
    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string storeGroupName(input logic [31:0] code);
        case (code)
            32'd1:   return "arith";
            32'd2:   return "shift";
            32'd3:   return "loadStore";
            32'd4:   return "branch";
            default: return "unknown";
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge Clock);
        #1;  // Drive point after the edge.
    endtask

    task automatic reportHang(input string what);
        $display("Timeout: %s", what);
        hung = 1'b1;
        errorCount++;
    endtask

    // Sampled at the falling edge. The prev values are what the core saw at the last rise.
    task automatic checkHandshake(input string port, input logic req, input logic ack,
                                  input logic prevReq, input logic prevAck);
        if (prevReq && !req && !prevAck) begin
            $display("Handshake error: %s req dropped before ack was raised", port);
            handshakeErrors++;
            errorCount++;
        end
        if (!prevReq && req && prevAck) begin
            $display("Handshake error: %s req raised again while ack was still high", port);
            handshakeErrors++;
            errorCount++;
        end
    endtask

    // ##################################################
    // Instruction memory responder
    initial begin : instrResponder
        int          waitCount;
        logic [31:0] randState;
        logic        firstSeen;
        instrAck  = 1'b0;
        instrData = '0;
        randState = seed;
        firstSeen = 1'b0;
        while (!hung) begin
            waitCount = 0;
            while (instrReq !== 1'b1 && waitCount < reqTimeout) begin
                nextCycle();
                waitCount++;
            end
            if (instrReq !== 1'b1) begin
                reportHang("the core made no instruction request");
                break;
            end
            if (!firstSeen) begin
                firstSeen = 1'b1;
                if (instrAddr !== resetPc) begin
                    $display("FAILED reset first fetch: expected %h, actual %h",
                             resetPc, instrAddr);
                    errorCount++;
                end else begin
                    $display("ok     reset: quiet ports, first fetch from %h", instrAddr);
                    passCount++;
                end
            end
            randState = lcgNext(randState);
            for (int d = 0; d < int'(randState[17:16]); d++)
                nextCycle();
            instrData = testData[instrAddr[8:2]];
            instrAck  = 1'b1;
            waitCount = 0;
            while (instrReq === 1'b1 && waitCount < ackTimeout) begin
                nextCycle();
                waitCount++;
            end
            if (instrReq === 1'b1) begin
                reportHang("instrReq stayed high after instrAck");
                break;
            end
            randState = lcgNext(randState);
            for (int d = 0; d < int'(randState[17:16]); d++)
                nextCycle();
            instrAck = 1'b0;
        end
    end

    // ##################################################
    // Data memory responder and store checks
    initial begin : dataResponder
        int          waitCount;
        logic [31:0] randState;
        logic [31:0] expAddr;
        logic [31:0] expData;
        string       name;
        dataAck   = 1'b0;
        dataRdata = '0;
        randState = lcgNext(seed);  // Own stream for this port.
        while (!hung) begin
            waitCount = 0;
            while (dataReq !== 1'b1 && waitCount < reqTimeout) begin
                nextCycle();
                waitCount++;
            end
            if (dataReq !== 1'b1) begin
                reportHang("the core made no data request");
                break;
            end
            if (dataWe === 1'b1) begin
                if (storeIndex >= storeCount) begin
                    $display("Unexpected store of %h to address %h after the last one",
                             dataWdata, dataAddr);
                    errorCount++;
                end else begin
                    expAddr = testData[storeBase + 3 * storeIndex];
                    expData = testData[storeBase + 3 * storeIndex + 1];
                    name    = $sformatf("%s store %0d",
                        storeGroupName(testData[storeBase + 3 * storeIndex + 2]),
                        storeIndex + 1);
                    if (dataAddr !== expAddr) begin
                        $display("FAILED %s address: expected %h, actual %h",
                                 name, expAddr, dataAddr);
                        errorCount++;
                    end else if (dataWdata !== expData) begin
                        $display("FAILED %s data: expected %h, actual %h",
                                 name, expData, dataWdata);
                        errorCount++;
                    end else begin
                        $display("ok     %s: %h to address %h", name, dataWdata, dataAddr);
                        passCount++;
                    end
                    storeIndex++;
                end
                dmem[dataAddr[7:2]] = dataWdata;
            end
            randState = lcgNext(randState);
            for (int d = 0; d < int'(randState[17:16]); d++)
                nextCycle();
            dataRdata = (dataWe === 1'b1) ? '0 : dmem[dataAddr[7:2]];
            dataAck   = 1'b1;
            waitCount = 0;
            while (dataReq === 1'b1 && waitCount < ackTimeout) begin
                nextCycle();
                waitCount++;
            end
            if (dataReq === 1'b1) begin
                reportHang("dataReq stayed high after dataAck");
                break;
            end
            randState = lcgNext(randState);
            for (int d = 0; d < int'(randState[17:16]); d++)
                nextCycle();
            dataAck = 1'b0;
        end
    end

    initial begin : handshakeMonitor
        logic prevInstrReq;
        logic prevInstrAck;
        logic prevDataReq;
        logic prevDataAck;
        prevInstrReq = 1'b0;
        prevInstrAck = 1'b0;
        prevDataReq  = 1'b0;
        prevDataAck  = 1'b0;
        forever begin
            @(negedge Clock);
            if (rstN === 1'b1) begin
                checkHandshake("instruction", instrReq, instrAck, prevInstrReq, prevInstrAck);
                checkHandshake("data", dataReq, dataAck, prevDataReq, prevDataAck);
                if (instrReq && !prevInstrReq)
                    instrRequests++;
                if (dataReq && !prevDataReq)
                    dataRequests++;
            end
            prevInstrReq = instrReq;
            prevInstrAck = instrAck;
            prevDataReq  = dataReq;
            prevDataAck  = dataAck;
        end
    end

    // ##################################################
    // Main sequence
    initial begin : mainSequence
        int cycleCount;
        errorCount      = 0;
        passCount       = 0;
        handshakeErrors = 0;
        storeIndex      = 0;
        instrRequests   = 0;
        dataRequests    = 0;
        hung            = 1'b0;
        rstN            = 1'b0;
        $readmemh("cpuTestdata.txt", testData);
        storeCount = int'(testData[storeCountPos]);
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'h5a5a0000 | 32'(i * 4);  // Byte address as fill.
        for (int i = 0; i < 4; i++)
            dmem[16 + i] = testData[dataInitBase + i];
        for (int i = 0; i < resetCycles; i++) begin
            nextCycle();
            if (instrReq !== 1'b0 || dataReq !== 1'b0) begin
                $display("FAILED reset requests: expected 00, actual %b%b", instrReq, dataReq);
                errorCount++;
            end
        end
        rstN = 1'b1;
        #1;
        if (instrReq !== 1'b0 || dataReq !== 1'b0) begin
            $display("FAILED requests after reset: expected 00, actual %b%b", instrReq, dataReq);
            errorCount++;
        end
        cycleCount = 0;
        while (storeIndex < storeCount && !hung && cycleCount < runLimit) begin
            nextCycle();
            cycleCount++;
        end
        if (!hung && storeIndex < storeCount) begin
            $display("Run stopped after %0d cycles with %0d of %0d stores seen",
                     cycleCount, storeIndex, storeCount);
            errorCount++;
        end
        $display("handshake: %0d violations in %0d instruction and %0d data requests",
                 handshakeErrors, instrRequests, dataRequests);
        $display("Summary: %0d checks passed, %0d errors, %0d of %0d stores seen",
                 passCount, errorCount, storeIndex, storeCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* cpuCore.sv */
`default_nettype none
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic            Clock,
    input  logic            rstN,
    output logic            instrReq,
    output logic [xlen-1:0] instrAddr,
    input  logic            instrAck,
    input  logic [xlen-1:0] instrData,
    output logic            dataReq,
    output logic            dataWe,
    output logic [xlen-1:0] dataAddr,
    output logic [xlen-1:0] dataWdata,
    input  logic            dataAck,
    input  logic [xlen-1:0] dataRdata
);

    logic               irLoad;
    logic               pcUpdate;
    logic               startAlu;
    logic               regWe;
    logic               takeBranch;
    logic               memToReg;
    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    instr;
    logic [xlen-1:0]    pcPlus4;
    logic [regIdxW-1:0] rs1;
    logic [regIdxW-1:0] rs2;
    logic [regIdxW-1:0] rd;
    logic [xlen-1:0]    imm;
    aluOp_t             aluOp;
    instrClass_t        instrClass;
    logic               useImm;
    logic [xlen-1:0]    rdata1;
    logic [xlen-1:0]    rdata2;
    logic [xlen-1:0]    aluB;
    logic [xlen-1:0]    result;
    logic               aluDone;
    logic               aluZero;
    logic [xlen-1:0]    wbData;

    // ##################################################
    // Operand and writeback paths
    assign aluB   = useImm ? imm : rdata2;
    assign wbData = memToReg ? dataRdata : (instrClass == jal) ? pcPlus4 : result;

    assign instrAddr = pc;
    assign dataAddr  = result;  // Effective address.
    assign dataWdata = rdata2;

    controlFsm uControl (
        .Clock      (Clock),
        .rstN       (rstN),
        .instrAck   (instrAck),
        .dataAck    (dataAck),
        .instrClass (instrClass),
        .aluDone    (aluDone),
        .aluZero    (aluZero),
        .instrReq   (instrReq),
        .irLoad     (irLoad),
        .aluStart   (startAlu),
        .regWe      (regWe),
        .pcUpdate   (pcUpdate),
        .takeBranch (takeBranch),
        .dataReq    (dataReq),
        .dataWe     (dataWe),
        .memToReg   (memToReg)
    );

    fetchUnit uFetch (
        .Clock      (Clock),
        .rstN       (rstN),
        .irLoad     (irLoad),
        .pcUpdate   (pcUpdate),
        .takeBranch (takeBranch),
        .instrData  (instrData),
        .imm        (imm),
        .pc         (pc),
        .instr      (instr),
        .pcPlus4    (pcPlus4)
    );

    instrDecoder uDecode (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .aluOp      (aluOp),
        .instrClass (instrClass),
        .useImm     (useImm)
    );

    regFile uRegs (
        .Clock  (Clock),
        .rstN   (rstN),
        .we     (regWe),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    serialAlu uAlu (
        .Clock  (Clock),
        .rstN   (rstN),
        .start  (startAlu),
        .op     (aluOp),
        .a      (rdata1),
        .b      (aluB),
        .result (result),
        .done   (aluDone),
        .zero   (aluZero)
    );

endmodule

`default_nettype wire

/* serialAlu.sv */
`default_nettype none
`timescale 1ns/1ps

module serialAlu import cpuPkg::*; (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            start,
    input  aluOp_t          op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            done,
    output logic            zero
);

    logic              busy;
    logic              shiftLeft;
    logic [shamtW-1:0] count;
    logic              isShift;
    logic              pending;

    assign isShift = (op == sll) || (op == srl);
    assign zero    = (result == '0);

    // ##################################################
    // Sequencing of the shift counter
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            shiftLeft <= 1'b0;
            count     <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                shiftLeft <= (op == sll);
                count     <= b[shamtW-1:0];
                busy      <= isShift && (b[shamtW-1:0] != '0);
                done      <= !isShift || (b[shamtW-1:0] == '0);  // Zero amount is immediate.
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == shamtW'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // One bit per cycle.
    always_ff @(posedge Clock) begin
        if (start) begin
            case (op)
                add:     result <= a + b;
                sub:     result <= a - b;
                andOp:   result <= a & b;
                orOp:    result <= a | b;
                default: result <= a;  // Shift operand.
            endcase
        end else if (busy) begin
            result <= shiftLeft ? {result[xlen-2:0], 1'b0} : {1'b0, result[xlen-1:1]};
        end
    end

    // Open operation, set by start and closed once done was seen.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            pending <= 1'b0;
        else if (start)
            pending <= 1'b1;
        else if (done)
            pending <= 1'b0;
    end

    doneAfterStart: assert property (@(posedge Clock) disable iff (!rstN)
        done |-> pending);

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               we,
    input  logic [regIdxW-1:0] rs1,
    input  logic [regIdxW-1:0] rs2,
    input  logic [regIdxW-1:0] rd,
    input  logic [xlen-1:0]    wdata,
    output logic [xlen-1:0]    rdata1,
    output logic [xlen-1:0]    rdata2
);

    logic [xlen-1:0] regs [numRegs];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;  // x0 is never written.
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    x0ReadsZero: assert property (@(posedge Clock) disable iff (!rstN)
        (rs1 == '0 -> rdata1 == '0) && (rs2 == '0 -> rdata2 == '0));

endmodule

`default_nettype wire

/* instrDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
    input  logic [xlen-1:0]    instr,
    output logic [regIdxW-1:0] rs1,
    output logic [regIdxW-1:0] rs2,
    output logic [regIdxW-1:0] rd,
    output logic [xlen-1:0]    imm,
    output aluOp_t             aluOp,
    output instrClass_t        instrClass,
    output logic               useImm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic            legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        instrClass = immOp;  // Unknown encodings become x0 = x0 + 0.
        aluOp      = add;
        imm        = '0;
        legal      = 1'b1;
        case (opcode)
            opcReg: begin
                instrClass = regOp;
                case (funct3)
                    3'b000:  aluOp = instr[30] ? sub : add;
                    3'b001:  aluOp = sll;
                    3'b101:  aluOp = srl;
                    3'b110:  aluOp = orOp;
                    3'b111:  aluOp = andOp;
                    default: legal = 1'b0;
                endcase
            end
            opcImm: begin
                imm   = immI;
                legal = (funct3 == 3'b000);  // ADDI only.
            end
            opcLoad: begin
                instrClass = load;
                imm        = immI;
                legal      = (funct3 == 3'b010);
            end
            opcStore: begin
                instrClass = store;
                imm        = immS;
                legal      = (funct3 == 3'b010);
            end
            opcBranch: begin
                aluOp = sub;  // Equality through the zero flag.
                imm   = immB;
                case (funct3)
                    3'b000:  instrClass = branchEq;
                    3'b001:  instrClass = branchNe;
                    default: legal = 1'b0;
                endcase
            end
            opcJal: begin
                instrClass = jal;
                imm        = immJ;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            instrClass = immOp;
            aluOp      = add;
            imm        = '0;
        end
        rd = legal ? instr[11:7] : '0;
    end

    assign useImm = (instrClass == immOp) || (instrClass == load) || (instrClass == store);

endmodule

`default_nettype wire

/* fetchUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            irLoad,
    input  logic            pcUpdate,
    input  logic            takeBranch,
    input  logic [xlen-1:0] instrData,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] instr,
    output logic [xlen-1:0] pcPlus4
);

    logic [xlen-1:0] nextPc;

    assign pcPlus4 = pc + xlen'(4);
    assign nextPc  = takeBranch ? pc + imm : pcPlus4;  // PC-relative target.

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc    <= resetPc;
            instr <= '0;  // Decodes as a no-op.
        end else begin
            if (pcUpdate)
                pc <= nextPc;
            if (irLoad)
                instr <= instrData;
        end
    end

endmodule

`default_nettype wire

/* controlFsm.sv */
`default_nettype none
`timescale 1ns/1ps

module controlFsm import cpuPkg::*; (
    input  logic        Clock,
    input  logic        rstN,
    input  logic        instrAck,
    input  logic        dataAck,
    input  instrClass_t instrClass,
    input  logic        aluDone,
    input  logic        aluZero,
    output logic        instrReq,
    output logic        irLoad,
    output logic        aluStart,
    output logic        regWe,
    output logic        pcUpdate,
    output logic        takeBranch,
    output logic        dataReq,
    output logic        dataWe,
    output logic        memToReg
);

    ctrlState_t state;
    ctrlState_t nextState;
    logic       isJump;
    logic       isMem;

    assign isJump = (instrClass == branchEq) || (instrClass == branchNe) || (instrClass == jal);
    assign isMem  = (instrClass == load) || (instrClass == store);

    // ##################################################
    // Sequencing
    always_comb begin
        nextState = state;
        case (state)
            fetchReq:
                if (instrAck)
                    nextState = fetchRelease;
            fetchRelease:
                if (!instrAck)
                    nextState = decode;
            decode:
                nextState = cpuPkg::aluStart;
            cpuPkg::aluStart:
                nextState = aluWait;
            aluWait:
                if (aluDone) begin
                    if (isJump)
                        nextState = wbJump;
                    else if (isMem)
                        nextState = memReq;
                    else
                        nextState = wbDefault;
                end
            memReq:
                if (dataAck)
                    nextState = memRelease;
            memRelease:
                if (!dataAck)
                    nextState = (instrClass == load) ? wbDefault : fetchReq;
            wbJump,
            wbDefault:
                nextState = fetchReq;
            default:
                nextState = fetchReq;
        endcase
    end

    // Registered so the port stays low in the first cycle out of reset.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state    <= fetchReq;
            instrReq <= 1'b0;
        end else begin
            state    <= nextState;
            instrReq <= (nextState == fetchReq);
        end
    end

    // ##################################################
    // Outputs
    assign irLoad   = instrReq && instrAck;  // Capture on ack.
    assign aluStart = (state == cpuPkg::aluStart);
    assign dataReq  = (state == memReq);
    assign dataWe   = dataReq && (instrClass == store);
    assign memToReg = dataReq;

    // Link write during the ALU phase, load data on ack.
    assign regWe = ((state == cpuPkg::aluStart || state == aluWait) && instrClass == jal)
                || (dataReq && dataAck && instrClass == load)
                || (state == wbDefault && instrClass != load);

    assign pcUpdate = (state == wbJump) || (state == wbDefault)
                   || (state == memRelease && !dataAck && instrClass == store);

    assign takeBranch = (instrClass == jal)
                     || (instrClass == branchEq && aluZero)
                     || (instrClass == branchNe && !aluZero);

    // ##################################################
    // Checks
    instrReqHeld: assert property (@(posedge Clock) disable iff (!rstN)
        $fell(instrReq) |-> $past(instrAck));

    dataReqHeld: assert property (@(posedge Clock) disable iff (!rstN)
        $fell(dataReq) |-> $past(dataAck));

    noWriteClash: assert property (@(posedge Clock) disable iff (!rstN)
        !(regWe && dataWe));

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int xlen    = 32;
    localparam int numRegs = 32;
    localparam int regIdxW = $clog2(numRegs);
    localparam int shamtW  = $clog2(xlen);

    localparam logic [xlen-1:0] resetPc = '0;  // First fetch address.

    // ##################################################
    // Major opcodes of the supported subset
    localparam logic [6:0] opcReg    = 7'b0110011;
    localparam logic [6:0] opcImm    = 7'b0010011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;

    typedef enum logic [3:0] {
        fetchReq,
        fetchRelease,
        decode,
        aluStart,
        aluWait,
        wbJump,
        memReq,
        memRelease,
        wbDefault
    } ctrlState_t;

    typedef enum logic [2:0] {add, sub, andOp, orOp, sll, srl} aluOp_t;

    typedef enum logic [2:0] {
        regOp,
        immOp,
        load,
        store,
        branchEq,
        branchNe,
        jal
    } instrClass_t;

endpackage

`default_nettype wire
